// File: timed_flag_unit.f
src/flag_pkg.sv
src/value_memory.sv
src/memory_scanner.sv
src/flag_regs.sv
src/timed_flag.sv
src/timed_flag_unit.sv
verification/timed_flag_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= timed_flag_tb
FILELIST  ?= timed_flag_unit.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timescale 1ns/1ns -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(BUILD_DIR)

// File: verification/timed_flag_cases.txt
// kind 1 bus write and readback: 1 addr wstrb wdata expected
// kind 2 setup and run: 2 disabled amount delay nlist list.. nsteps (sel done flag)..
// kind 3 bus read: 3 addr expected, kind 4 more steps: 4 nsteps (sel done flag)..
// sel indexes the list and ff is LFSR filler, flag 1 means out0 all ones, kind 0 ends
1 005 f 11223344 11223344
1 005 5 aabbccdd 11bb33dd
1 201 f 0000002a 0000002a
1 200 f 00000007 00000007
1 202 f 00000002 00000002
3 203 80000000
2 0 3 0 3 a5a50001 a5a50002 a5a50003 3 0 0 0 0 0 1 ff 0 0
3 203 00000002
4 3 0 0 0 1 0 1 ff 0 0
3 203 00000001
4 3 2 0 1 ff 1 0 2 1 0
3 203 80000000
2 0 2 3 2 b0b00010 b0b00020 7 0 0 0 0 0 0 0 0 0 0 0 1 ff 0 0 1 0 1 ff 1 0
3 203 80000000
3 201 00000003
2 1 2 0 2 c0c00001 c0c00002 4 0 1 0 0 1 0 1 1 0 ff 1 0
3 203 80000000
3 202 00000002
2 0 3 0 3 d0d00001 d0d00002 d0d00003 5 ff 0 0 0 0 1 ff 0 0 1 0 1 ff 0 0
3 203 00000001
2 0 3 0 3 d0d00001 d0d00002 d0d00003 7 ff 0 0 0 0 1 ff 0 0 1 0 1 ff 0 0 2 0 1 ff 1 0
3 203 80000000
0

// File: verification/timed_flag_tb.sv
`default_nettype none

module timed_flag_tb;

   timeunit 1ns;
   timeprecision 1ns;

   import flag_pkg::*;

   localparam int DATA_W      = 32;
   localparam int ADDR_W      = 10;
   localparam int MEM_ADDR_W  = 8;
   localparam int half_period = 50;

   logic                clk = 1'b0;
   logic                rst;
   logic                valid;
   logic [DATA_W/8-1:0] wstrb;
   logic [ADDR_W-1:0]   addr;
   logic [DATA_W-1:0]   wdata;
   logic                ready;
   logic [DATA_W-1:0]   rdata;
   logic [word_w-1:0]   in0;
   logic [word_w-1:0]   out0;
   logic                done;

   logic [31:0]       case_words [0:511];
   logic [word_w-1:0] list_vals [0:255];
   int                list_len = 0;
   logic [15:0]       lfsr = 16'd90;
   int                test_no = 0;
   int                checks = 0;
   int                errors = 0;
   longint            limit_ns = 0;

   timed_flag_unit #(
      .DATA_W     (DATA_W),
      .ADDR_W     (ADDR_W),
      .MEM_ADDR_W (MEM_ADDR_W)
   ) dut (.*);

   always #(half_period) clk = ~clk;

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // x^16 + x^14 + x^13 + x^11 + 1
   endfunction

   function automatic logic [ADDR_W-1:0] reg_addr(input reg_sel_t sel);
      return {1'b1, {(ADDR_W - 3){1'b0}}, sel}; // top address bit picks the registers
   endfunction

   // bus cycles and stream steps of the case starting at pos, and its size in words
   function automatic int case_cycles(input int pos, output int words);
      int n;
      int ns;
      n     = int'(case_words[pos + 4]);
      ns    = int'(case_words[pos + 5 + n]);
      words = 1;
      case (int'(case_words[pos]))
         1: begin
            words = 5;
            return 4;
         end
         2: begin
            words = 6 + n + 3 * ns;
            return 2 * (n + 3) + ns;
         end
         3: begin
            words = 3;
            return 2;
         end
         4: begin
            ns    = int'(case_words[pos + 1]);
            words = 2 + 3 * ns;
            return ns;
         end
         default: return 0;
      endcase
   endfunction

   task automatic next_filler(output logic [word_w-1:0] w);
      for (int i = 0; i < word_w; i++) begin
         lfsr = lfsr_next(lfsr);
         w[i] = lfsr[0];
      end
   endtask

   task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL test %0d %s: got %h, expected %h", test_no, name, got, exp);
      end
   endtask

   task automatic check_flag(input logic [word_w-1:0] got, input logic [word_w-1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL test %0d out0: got %h, expected %h", test_no, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL test %0d %s: got %h, expected %h", test_no, name, got, exp);
      end
   endtask

   // one request, ready must follow valid by exactly one cycle
   task automatic bus_op(input logic [ADDR_W-1:0] a, input logic [DATA_W/8-1:0] strb,
                         input logic [DATA_W-1:0] data, input logic is_read,
                         input logic [DATA_W-1:0] exp);
      logic [word_w-1:0] fill;
      next_filler(fill);
      in0   = fill;
      valid = 1'b1;
      wstrb = strb;
      addr  = a;
      wdata = data;
      @(negedge clk);
      check_bit("ready", ready, 1'b1);
      if (is_read) begin
         check_word("rdata", rdata, exp);
      end
      valid = 1'b0;
      wstrb = '0;
      @(negedge clk);
      check_bit("ready", ready, 1'b0);
   endtask

   task automatic run_steps(input int p);
      logic [word_w-1:0] val;
      int                sel;
      for (int j = 0; j < int'(case_words[p]); j++) begin
         sel = int'(case_words[p + 1 + 3 * j]);
         if (sel == 'hff) begin
            next_filler(val);
         end else if (sel < list_len) begin
            val = list_vals[sel];
         end else begin
            errors++;
            $display("test %0d refers to a list entry past the end of the list", test_no);
            val = '0;
         end
         in0 = val;
         #(half_period / 2); // flag is combinational, sample mid cycle
         check_flag(out0, {word_w{case_words[p + 3 + 3 * j][0]}});
         check_bit("done", done, case_words[p + 2 + 3 * j][0]);
         @(negedge clk);
      end
   endtask

   initial begin : main
      int                pos;
      int                words;
      int                kind;
      int                n;
      int                ncases;
      int                longest;
      int                failed;
      int                errs_before;
      logic [DATA_W-1:0] ctrl;
      rst   = 1'b1;
      valid = 1'b0;
      wstrb = '0;
      addr  = '0;
      wdata = '0;
      in0   = '0;
      for (int i = 0; i < 512; i++) begin
         case_words[i] = '0;
      end
      $readmemh("verification/timed_flag_cases.txt", case_words);
      pos     = 0;
      ncases  = 0;
      longest = 0;
      failed  = 0;
      while (pos < 512 && case_words[pos] != '0) begin
         n = case_cycles(pos, words) + 4;
         longest = (n > longest) ? n : longest;
         ncases++;
         pos += words;
      end
      limit_ns = longint'(ncases) * longint'(longest) * 100;
      repeat (2) @(negedge clk);
      rst = 1'b0;
      check_bit("done", done, 1'b1);
      check_flag(out0, '0);
      check_bit("ready", ready, 1'b0);
      if (ncases == 0) begin
         errors++;
         $display("no cases were read from the case file");
      end
      pos = 0;
      while (pos < 512 && case_words[pos] != '0) begin
         test_no++;
         errs_before = errors;
         kind = int'(case_words[pos]);
         void'(case_cycles(pos, words));
         case (kind)
            1: begin
               bus_op(case_words[pos + 1][ADDR_W-1:0], case_words[pos + 2][DATA_W/8-1:0],
                      case_words[pos + 3], 1'b0, '0);
               bus_op(case_words[pos + 1][ADDR_W-1:0], '0, '0, 1'b1, case_words[pos + 4]);
            end
            2: begin
               n = int'(case_words[pos + 4]);
               for (int i = 0; i < n; i++) begin
                  list_vals[i] = case_words[pos + 5 + i];
                  bus_op(ADDR_W'(i), '1, case_words[pos + 5 + i], 1'b0, '0);
               end
               list_len = n;
               ctrl = '0;
               ctrl[ctrl_run_bit] = 1'b1;
               ctrl[ctrl_disable_bit] = case_words[pos + 1][0];
               bus_op(reg_addr(reg_amount), '1, case_words[pos + 2], 1'b0, '0);
               bus_op(reg_addr(reg_delay), '1, case_words[pos + 3], 1'b0, '0);
               bus_op(reg_addr(reg_control), '1, ctrl, 1'b0, '0);
               run_steps(pos + 5 + n);
            end
            3: bus_op(case_words[pos + 1][ADDR_W-1:0], '0, '0, 1'b1, case_words[pos + 2]);
            4: run_steps(pos + 1);
            default: begin
               errors++;
               $display("the case file has an unknown case kind %0d at word %0d", kind, pos);
               words = 512;
            end
         endcase
         if (errors == errs_before) begin
            $display("test %0d kind %0d passed", test_no, kind);
         end else begin
            failed++;
            $display("test %0d kind %0d failed with %0d errors", test_no, kind,
                     errors - errs_before);
         end
         pos += words;
      end
      $display("tests %0d, failed %0d, checks %0d, errors %0d", test_no, failed, checks, errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

   initial begin : watchdog
      wait (limit_ns != 0);
      #(limit_ns);
      $display("timeout, the cases did not finish within %0d ns", limit_ns);
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: src/timed_flag_unit.sv
`default_nettype none

module timed_flag_unit #(
   parameter int DATA_W     = 32,
   parameter int ADDR_W     = 10,
   parameter int MEM_ADDR_W = 8
) (
   input wire                          clk,
   input wire                          rst,
   input wire                          valid,
   input wire [DATA_W/8-1:0]           wstrb,
   input wire [ADDR_W-1:0]             addr,
   input wire [DATA_W-1:0]             wdata,
   output logic                        ready,
   output logic [DATA_W-1:0]           rdata,
   input wire [flag_pkg::word_w-1:0]   in0,
   output logic [flag_pkg::word_w-1:0] out0,
   output logic                        done
);

   import flag_pkg::*;

   logic                  mem_we;
   logic [DATA_W-1:0]     mem_rdata;
   logic [word_w-1:0]     amount;
   logic [word_w-1:0]     delay0;
   logic                  disabled;
   logic                  run;
   logic [word_w-1:0]     remaining;
   logic [MEM_ADDR_W-1:0] scan_addr;
   logic                  scan_enable;
   logic [DATA_W-1:0]     scan_data;
   logic [DATA_W-1:0]     current_value;
   logic                  current_valid;
   logic                  advance;

   flag_regs #(
      .DATA_W (DATA_W),
      .ADDR_W (ADDR_W)
   ) regs (
      .clk       (clk),
      .rst       (rst),
      .valid     (valid),
      .wstrb     (wstrb),
      .addr      (addr),
      .wdata     (wdata),
      .mem_rdata (mem_rdata),
      .done      (done),
      .remaining (remaining),
      .ready     (ready),
      .rdata     (rdata),
      .mem_we    (mem_we),
      .amount    (amount),
      .delay0    (delay0),
      .disabled  (disabled),
      .run       (run)
   );

   value_memory #(
      .DATA_W     (DATA_W),
      .MEM_ADDR_W (MEM_ADDR_W)
   ) values (
      .clk         (clk),
      .bus_addr    (addr[MEM_ADDR_W-1:0]),
      .bus_wdata   (wdata),
      .bus_wstrb   (wstrb),
      .bus_we      (mem_we),
      .bus_rdata   (mem_rdata),
      .scan_addr   (scan_addr),
      .scan_enable (scan_enable),
      .scan_data   (scan_data)
   );

   // a run also rewinds the list to entry zero
   memory_scanner #(
      .DATA_W     (DATA_W),
      .MEM_ADDR_W (MEM_ADDR_W)
   ) scanner (
      .clk           (clk),
      .rst           (rst),
      .restart       (run),
      .advance       (advance),
      .scan_data     (scan_data),
      .scan_addr     (scan_addr),
      .scan_enable   (scan_enable),
      .current_value (current_value),
      .current_valid (current_valid)
   );

   timed_flag engine (
      .clk           (clk),
      .rst           (rst),
      .run           (run),
      .amount        (amount),
      .delay0        (delay0),
      .disabled      (disabled),
      .in0           (in0),
      .current_value (current_value),
      .current_valid (current_valid),
      .advance       (advance),
      .out0          (out0),
      .done          (done),
      .remaining     (remaining)
   );

endmodule

`default_nettype wire

// File: src/timed_flag.sv
`default_nettype none

module timed_flag (
   input wire                          clk,
   input wire                          rst,
   input wire                          run,
   input wire [flag_pkg::word_w-1:0]   amount,
   input wire [flag_pkg::word_w-1:0]   delay0,
   input wire                          disabled,
   input wire [flag_pkg::word_w-1:0]   in0,
   input wire [flag_pkg::word_w-1:0]   current_value,
   input wire                          current_valid,
   output logic                        advance,
   output logic [flag_pkg::word_w-1:0] out0,
   output logic                        done,
   output logic [flag_pkg::word_w-1:0] remaining
);

   import flag_pkg::*;

   flag_state_t       state;
   logic [word_w-1:0] delay_cnt;
   logic              match;
   logic              last_match;

   assign match      = current_valid && (in0 == current_value);
   assign advance    = (state == st_count) && (remaining != '0) && match;
   assign last_match = advance && (remaining == word_w'(1));
   assign done       = (remaining == '0);

   // flag follows in0 in the same cycle
   assign out0 = {word_w{(state == st_count) && !disabled && match}};

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state     <= st_idle;
         delay_cnt <= '0;
         remaining <= '0;
      end else if (run && !disabled) begin
         state     <= st_delay;
         delay_cnt <= delay0;
         remaining <= amount;
      end else begin
         case (state)
            st_delay: begin
               if (delay_cnt != '0) begin
                  delay_cnt <= delay_cnt - 1'b1;
               end
               // a zero delay still spends the cycle the scanner needs anyway
               if (delay_cnt == '0 || delay_cnt == word_w'(1)) begin
                  state <= st_count;
               end
            end
            st_count: begin
               if (advance) begin
                  remaining <= remaining - 1'b1;
               end
               if (remaining == '0 || last_match) begin
                  state <= st_done;
               end
            end
            default: begin
               state <= state; // idle and done wait for the next run
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: src/flag_regs.sv
`default_nettype none

module flag_regs #(
   parameter int DATA_W = 32,
   parameter int ADDR_W = 10
) (
   input wire                          clk,
   input wire                          rst,
   input wire                          valid,
   input wire [DATA_W/8-1:0]           wstrb,
   input wire [ADDR_W-1:0]             addr,
   input wire [DATA_W-1:0]             wdata,
   input wire [DATA_W-1:0]             mem_rdata,
   input wire                          done,
   input wire [flag_pkg::word_w-1:0]   remaining,
   output logic                        ready,
   output logic [DATA_W-1:0]           rdata,
   output logic                        mem_we,
   output logic [flag_pkg::word_w-1:0] amount,
   output logic [flag_pkg::word_w-1:0] delay0,
   output logic                        disabled,
   output logic                        run
);

   import flag_pkg::*;

   logic              is_reg;
   logic              is_write;
   logic              reg_write;
   reg_sel_t          sel;
   logic [DATA_W-1:0] ctrl_word;
   logic [DATA_W-1:0] reg_read;
   logic [DATA_W-1:0] reg_rdata_q;
   logic              rd_reg_q; // the pending read targets the registers

   assign is_reg    = addr[ADDR_W-1];
   assign is_write  = |wstrb;
   assign sel       = reg_sel_t'(addr[1:0]);
   assign mem_we    = valid & is_write & ~is_reg;
   assign reg_write = valid & is_write & is_reg;

   always_comb begin
      ctrl_word                   = '0;
      ctrl_word[ctrl_run_bit]     = run;
      ctrl_word[ctrl_disable_bit] = disabled;
   end

   always_comb begin
      case (sel)
         reg_amount:  reg_read = DATA_W'(amount);
         reg_delay:   reg_read = DATA_W'(delay0);
         reg_control: reg_read = ctrl_word;
         default:     reg_read = DATA_W'({done, remaining[word_w-2:0]}); // done sits in bit 31
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ready    <= 1'b0;
         rd_reg_q <= 1'b0;
         run      <= 1'b0;
         amount   <= '0;
         delay0   <= '0;
         disabled <= 1'b0;
      end else begin
         ready <= valid;
         run   <= 1'b0;
         if (valid) begin
            rd_reg_q <= is_reg;
         end
         if (reg_write) begin
            case (sel)
               reg_amount: amount <= wdata[word_w-1:0];
               reg_delay:  delay0 <= wdata[word_w-1:0];
               reg_control: begin
                  disabled <= wdata[ctrl_disable_bit];
                  // a run written together with the disable bit is dropped
                  run      <= wdata[ctrl_run_bit] & ~wdata[ctrl_disable_bit];
               end
               default: amount <= amount; // status is read only
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (valid) begin
         reg_rdata_q <= reg_read;
      end
   end

   assign rdata = rd_reg_q ? reg_rdata_q : mem_rdata;

endmodule

`default_nettype wire

// File: src/memory_scanner.sv
`default_nettype none

module memory_scanner #(
   parameter int DATA_W     = 32,
   parameter int MEM_ADDR_W = 8
) (
   input wire                    clk,
   input wire                    rst,
   input wire                    restart,
   input wire                    advance,
   input wire [DATA_W-1:0]       scan_data,
   output logic [MEM_ADDR_W-1:0] scan_addr,
   output logic                  scan_enable,
   output logic [DATA_W-1:0]     current_value,
   output logic                  current_valid
);

   logic [MEM_ADDR_W-1:0] addr_q;
   logic [MEM_ADDR_W-1:0] next_addr;
   logic                  pending; // a read was issued at the last edge

   // the new address goes straight to the memory so only one cycle is lost
   always_comb begin
      if (restart) begin
         next_addr = '0;
      end else if (advance) begin
         next_addr = addr_q + 1'b1;
      end else begin
         next_addr = addr_q;
      end
   end

   assign scan_addr   = next_addr;
   assign scan_enable = restart | advance; // read only when the entry changes

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         addr_q        <= '0;
         pending       <= 1'b0;
         current_valid <= 1'b0;
      end else begin
         addr_q  <= next_addr;
         pending <= scan_enable;
         if (scan_enable) begin
            current_valid <= 1'b0; // old entry is stale while the read is in flight
         end else if (pending) begin
            current_valid <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (pending) begin
         current_value <= scan_data; // held until the next advance
      end
   end

endmodule

`default_nettype wire

// File: src/value_memory.sv
`default_nettype none

module value_memory #(
   parameter int DATA_W     = 32,
   parameter int MEM_ADDR_W = 8
) (
   input wire                    clk,
   input wire [MEM_ADDR_W-1:0]   bus_addr,
   input wire [DATA_W-1:0]       bus_wdata,
   input wire [DATA_W/8-1:0]     bus_wstrb,
   input wire                    bus_we,
   output logic [DATA_W-1:0]     bus_rdata,
   input wire [MEM_ADDR_W-1:0]   scan_addr,
   input wire                    scan_enable,
   output logic [DATA_W-1:0]     scan_data
);

   logic [DATA_W-1:0] mem [0:2**MEM_ADDR_W-1];

   // port 1 belongs to the bus, read returns the old word on a write
   always_ff @(posedge clk) begin
      if (bus_we) begin
         for (int lane = 0; lane < DATA_W / 8; lane++) begin
            if (bus_wstrb[lane]) begin
               mem[bus_addr][lane*8 +: 8] <= bus_wdata[lane*8 +: 8];
            end
         end
      end
      bus_rdata <= mem[bus_addr];
   end

   // port 0 is read only and feeds the scanner
   always_ff @(posedge clk) begin
      if (scan_enable) begin
         scan_data <= mem[scan_addr];
      end
   end

endmodule

`default_nettype wire

// File: src/flag_pkg.sv
`default_nettype none

package flag_pkg;

   // width of amount, delay, in0 and out0
   localparam int word_w = 32;

   // register select, taken from the low two address bits
   typedef enum logic [1:0] {
      reg_amount  = 2'd0,
      reg_delay   = 2'd1,
      reg_control = 2'd2,
      reg_status  = 2'd3
   } reg_sel_t;

   typedef enum logic [1:0] {
      st_idle,
      st_delay,
      st_count,
      st_done
   } flag_state_t;

   // bit positions in the control register
   localparam int ctrl_run_bit     = 0; // self-clearing
   localparam int ctrl_disable_bit = 1;

endpackage

`default_nettype wire
